// ==== list.f ====
source/dcache_pkg.sv
source/dcache_data_store.sv
source/dcache_tag_store.sv
source/dcache_bus_engine.sv
source/dcache_ctrl.sv
source/dcache_top.sv
verification/dcache_props.sv
verification/dcache_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the data cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module dcache_tb -f list.f -o dcache_sim
./obj_dir/dcache_sim > sim.log 2>&1
cat sim.log

if grep -q "Regression failed" sim.log; then
    exit 1
fi
exit 0

// ==== source/dcache_bus_engine.sv ====
/*
 * Bus burst engine for 8-beat line fill and dirty line write-back
 * Beat counting, address generation and write data prefetch
 */
`timescale 1ns/10ps
`default_nettype none

module dcache_bus_engine (
    input  wire                      clk,
    input  wire                      srst_n,
    input  wire                      wb_start_i,
    input  wire                      fill_start_i,
    input  wire dcache_pkg::index_t  burst_index_i,
    input  wire dcache_pkg::tag_t    burst_tag_i,
    input  wire dcache_pkg::word_t   mem_rdata_i,
    output dcache_pkg::offset_t      beat_offset_o,
    output logic                     fill_we_o,
    output dcache_pkg::word_t        fill_data_o,
    output logic                     burst_done_o,
    output logic                     bus_req_o,
    output logic                     bus_we_o,
    input  wire                      bus_accept_i,
    output dcache_pkg::addr_t        bus_addr_o,
    output dcache_pkg::word_t        bus_wdata_o,
    input  wire dcache_pkg::word_t   bus_rdata_i
);

    logic                active_q, wb_q, prime_q;
    dcache_pkg::offset_t cnt_q;
    dcache_pkg::tag_t    tag_q;
    dcache_pkg::index_t  index_q;
    dcache_pkg::word_t   wdata_q;
    logic                beat, last;

    assign bus_req_o   = active_q && !prime_q;
    assign bus_we_o    = active_q && wb_q;
    assign bus_addr_o  = {tag_q, index_q, cnt_q, 2'b00};
    assign bus_wdata_o = wdata_q;

    assign beat        = bus_req_o && bus_accept_i;
    assign last        = (cnt_q == dcache_pkg::offset_t'(dcache_pkg::LINE_WORDS - 1));
    assign fill_we_o   = beat && !wb_q;
    assign fill_data_o = bus_rdata_i;

    // Write-back reads run one word ahead of the beat held on the bus
    always_comb begin
        if (active_q && wb_q) begin
            if (prime_q) begin
                beat_offset_o = dcache_pkg::offset_t'(1);
            end else begin
                beat_offset_o = cnt_q + (beat ? dcache_pkg::offset_t'(2) : dcache_pkg::offset_t'(1));
            end
        end else begin
            beat_offset_o = cnt_q;
        end
    end

    always_ff @(posedge clk) begin
        if (!srst_n) begin
            active_q     <= 1'b0;
            wb_q         <= 1'b0;
            prime_q      <= 1'b0;
            cnt_q        <= '0;
            burst_done_o <= 1'b0;
        end else begin
            burst_done_o <= beat && last;
            if (wb_start_i || fill_start_i) begin
                active_q <= 1'b1;
                wb_q     <= wb_start_i;
                prime_q  <= wb_start_i;
                cnt_q    <= '0;
            end else if (prime_q) begin
                prime_q <= 1'b0;
            end else if (beat) begin
                cnt_q <= cnt_q + dcache_pkg::offset_t'(1);
                if (last) begin
                    active_q <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wb_start_i || fill_start_i) begin
            tag_q   <= burst_tag_i;
            index_q <= burst_index_i;
        end
        if (prime_q || (beat && wb_q)) begin
            wdata_q <= mem_rdata_i;
        end
    end

endmodule

`default_nettype wire

// ==== source/dcache_ctrl.sv ====
/*
 * Cache controller with miss FSM, accepted request latch
 * and data store port steering between core access and bursts
 */
`timescale 1ns/10ps
`default_nettype none

module dcache_ctrl (
    input  wire                       clk,
    input  wire                       srst_n,
    input  wire                       rd_req_i,
    input  wire dcache_pkg::byte_en_t wr_be_i,
    input  wire dcache_pkg::addr_t    addr_i,
    input  wire dcache_pkg::word_t    wdata_i,
    output logic                      req_accept_o,
    output logic                      busy_o,
    output logic                      rdata_valid_o,
    output logic                      wr_done_o,
    output dcache_pkg::word_t         rdata_o,
    output dcache_pkg::index_t        look_index_o,
    output dcache_pkg::tag_t          look_tag_o,
    input  wire                       hit_i,
    input  wire dcache_pkg::way_t     hit_way_i,
    input  wire dcache_pkg::way_t     victim_way_i,
    input  wire                       victim_dirty_i,
    input  wire dcache_pkg::tag_t     victim_tag_i,
    output logic                      touch_o,
    output logic                      set_dirty_o,
    output logic                      install_o,
    output dcache_pkg::way_t          upd_way_o,
    output logic                      mem_en_o,
    output dcache_pkg::byte_en_t      mem_be_o,
    output dcache_pkg::way_t          mem_way_o,
    output dcache_pkg::index_t        mem_index_o,
    output dcache_pkg::offset_t       mem_offset_o,
    output dcache_pkg::word_t         mem_wdata_o,
    input  wire dcache_pkg::word_t    mem_rdata_i,
    output logic                      wb_start_o,
    output logic                      fill_start_o,
    output dcache_pkg::index_t        burst_index_o,
    output dcache_pkg::tag_t          burst_tag_o,
    input  wire                       burst_done_i,
    input  wire dcache_pkg::offset_t  beat_offset_i,
    input  wire                       fill_we_i,
    input  wire dcache_pkg::word_t    fill_data_i
);

    dcache_pkg::cache_state_e state_q, state_d;
    dcache_pkg::addr_t        addr_q, cur_addr;
    dcache_pkg::byte_en_t     be_q;
    dcache_pkg::word_t        wdata_q;
    dcache_pkg::way_t         way_q;
    logic                     idle, hit_acc, miss_acc, replay;

    assign idle     = (state_q == dcache_pkg::IDLE);
    assign replay   = (state_q == dcache_pkg::REPLAY);
    assign cur_addr = idle ? addr_i : addr_q;

    assign look_index_o = cur_addr[2 + dcache_pkg::OFFSET_W +: dcache_pkg::INDEX_W];
    assign look_tag_o   = cur_addr[31 -: dcache_pkg::TAG_W];

    assign req_accept_o = idle && (rd_req_i || (|wr_be_i));
    assign busy_o       = !idle;
    assign hit_acc      = req_accept_o && hit_i;
    assign miss_acc     = req_accept_o && !hit_i;
    assign rdata_o      = mem_rdata_i;

    // LRU and dirty bookkeeping for hits and the replayed access
    assign touch_o     = hit_acc || replay;
    assign set_dirty_o = (hit_acc && (|wr_be_i)) || (replay && (|be_q));
    assign install_o   = (state_q == dcache_pkg::FILL) && burst_done_i;
    assign upd_way_o   = idle ? hit_way_i : way_q;

    assign wb_start_o    = miss_acc && victim_dirty_i;
    assign fill_start_o  = (miss_acc && !victim_dirty_i)
                         || ((state_q == dcache_pkg::WRITE_BACK) && burst_done_i);
    assign burst_index_o = look_index_o;
    assign burst_tag_o   = wb_start_o ? victim_tag_i : look_tag_o;

    always_comb begin
        mem_en_o     = 1'b0;
        mem_be_o     = '0;
        mem_way_o    = way_q;
        mem_index_o  = look_index_o;
        mem_offset_o = cur_addr[2 +: dcache_pkg::OFFSET_W];
        mem_wdata_o  = idle ? wdata_i : wdata_q;
        case (state_q)
            dcache_pkg::IDLE: begin
                mem_en_o = req_accept_o;
                if (hit_i) begin
                    mem_way_o = hit_way_i;
                    mem_be_o  = wr_be_i;
                end else begin
                    // Fetch the first victim word ahead of a possible write-back
                    mem_way_o    = victim_way_i;
                    mem_offset_o = beat_offset_i;
                end
            end
            dcache_pkg::WRITE_BACK: begin
                mem_en_o     = 1'b1;
                mem_offset_o = beat_offset_i;
            end
            dcache_pkg::FILL: begin
                mem_en_o     = fill_we_i;
                mem_be_o     = {4{fill_we_i}};
                mem_offset_o = beat_offset_i;
                mem_wdata_o  = fill_data_i;
            end
            default: begin
                mem_en_o = 1'b1;
                mem_be_o = be_q;
            end
        endcase
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            dcache_pkg::IDLE: begin
                if (miss_acc) begin
                    state_d = victim_dirty_i ? dcache_pkg::WRITE_BACK : dcache_pkg::FILL;
                end
            end
            dcache_pkg::WRITE_BACK: if (burst_done_i) state_d = dcache_pkg::FILL;
            dcache_pkg::FILL:       if (burst_done_i) state_d = dcache_pkg::REPLAY;
            default:                state_d = dcache_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!srst_n) begin
            state_q       <= dcache_pkg::IDLE;
            rdata_valid_o <= 1'b0;
            wr_done_o     <= 1'b0;
        end else begin
            state_q       <= state_d;
            rdata_valid_o <= (hit_acc && !(|wr_be_i)) || (replay && !(|be_q));
            wr_done_o     <= (hit_acc && (|wr_be_i)) || (replay && (|be_q));
        end
    end

    always_ff @(posedge clk) begin
        if (req_accept_o) begin
            addr_q  <= addr_i;
            be_q    <= wr_be_i;
            wdata_q <= wdata_i;
        end
        if (miss_acc) begin
            way_q <= victim_way_i;
        end
    end

endmodule

`default_nettype wire

// ==== source/dcache_data_store.sv ====
/*
 * Line data memory, one 512-word array per way
 * Byte-enabled writes and registered reads
 */
`timescale 1ns/10ps
`default_nettype none

module dcache_data_store (
    input  wire                       clk,
    input  wire                       en_i,
    input  wire dcache_pkg::byte_en_t be_i,
    input  wire dcache_pkg::way_t     way_i,
    input  wire dcache_pkg::index_t   index_i,
    input  wire dcache_pkg::offset_t  offset_i,
    input  wire dcache_pkg::word_t    wdata_i,
    output dcache_pkg::word_t         rdata_o
);

    localparam int DEPTH = dcache_pkg::NUM_SETS * dcache_pkg::LINE_WORDS;

    dcache_pkg::word_t mem_q [dcache_pkg::NUM_WAYS][DEPTH];
    logic [dcache_pkg::INDEX_W+dcache_pkg::OFFSET_W-1:0] word_addr;

    assign word_addr = {index_i, offset_i};

    always_ff @(posedge clk) begin
        for (int b = 0; b < 4; b++) begin
            if (en_i && be_i[b]) begin
                mem_q[way_i][word_addr][8*b +: 8] <= wdata_i[8*b +: 8];
            end
        end
        // Output holds its last word when no read is issued
        if (en_i && (be_i == '0)) begin
            rdata_o <= mem_q[way_i][word_addr];
        end
    end

endmodule

`default_nettype wire

// ==== source/dcache_pkg.sv ====
/*
 * Data cache geometry constants, field types for addresses and data,
 * and the miss-handling state encoding
 */
`default_nettype none

package dcache_pkg;

    localparam int NUM_WAYS   = 2;
    localparam int NUM_SETS   = 64;
    localparam int LINE_WORDS = 8;
    localparam int INDEX_W    = 6;
    localparam int OFFSET_W   = 3;
    // Remaining upper address bits after index, word offset and byte offset
    localparam int TAG_W      = 32 - INDEX_W - OFFSET_W - 2;

    typedef logic [31:0]          addr_t;
    typedef logic [31:0]          word_t;
    typedef logic [3:0]           byte_en_t;
    typedef logic [TAG_W-1:0]     tag_t;
    typedef logic [INDEX_W-1:0]   index_t;
    typedef logic [OFFSET_W-1:0]  offset_t;
    typedef logic                 way_t;

    typedef enum logic [1:0] {
        IDLE,
        WRITE_BACK,
        FILL,
        REPLAY
    } cache_state_e;

endpackage

`default_nettype wire

// ==== source/dcache_tag_store.sv ====
/*
 * Tag, valid and dirty arrays for both ways with per-set LRU bit
 * Hit lookup, victim selection and update port
 */
`timescale 1ns/10ps
`default_nettype none

module dcache_tag_store (
    input  wire                      clk,
    input  wire                      srst_n,
    input  wire dcache_pkg::index_t  look_index_i,
    input  wire dcache_pkg::tag_t    look_tag_i,
    output logic                     hit_o,
    output dcache_pkg::way_t         hit_way_o,
    output dcache_pkg::way_t         victim_way_o,
    output logic                     victim_dirty_o,
    output dcache_pkg::tag_t         victim_tag_o,
    input  wire                      touch_i,
    input  wire                      set_dirty_i,
    input  wire                      install_i,
    input  wire dcache_pkg::way_t    upd_way_i
);

    dcache_pkg::tag_t tag_q   [dcache_pkg::NUM_WAYS][dcache_pkg::NUM_SETS];
    logic             valid_q [dcache_pkg::NUM_WAYS][dcache_pkg::NUM_SETS];
    logic             dirty_q [dcache_pkg::NUM_WAYS][dcache_pkg::NUM_SETS];
    dcache_pkg::way_t lru_q   [dcache_pkg::NUM_SETS];

    always_comb begin
        hit_o     = 1'b0;
        hit_way_o = '0;
        for (int w = 0; w < dcache_pkg::NUM_WAYS; w++) begin
            if (valid_q[w][look_index_i] && (tag_q[w][look_index_i] == look_tag_i)) begin
                hit_o     = 1'b1;
                hit_way_o = dcache_pkg::way_t'(w);
            end
        end
    end

    // An empty way is filled before anything is evicted
    always_comb begin
        if (!valid_q[0][look_index_i]) begin
            victim_way_o = 1'b0;
        end else if (!valid_q[1][look_index_i]) begin
            victim_way_o = 1'b1;
        end else begin
            victim_way_o = lru_q[look_index_i];
        end
    end

    assign victim_dirty_o = valid_q[victim_way_o][look_index_i]
                         && dirty_q[victim_way_o][look_index_i];
    assign victim_tag_o   = tag_q[victim_way_o][look_index_i];

    always_ff @(posedge clk) begin
        if (!srst_n) begin
            for (int s = 0; s < dcache_pkg::NUM_SETS; s++) begin
                lru_q[s] <= 1'b0;
                for (int w = 0; w < dcache_pkg::NUM_WAYS; w++) begin
                    valid_q[w][s] <= 1'b0;
                    dirty_q[w][s] <= 1'b0;
                end
            end
        end else begin
            if (install_i) begin
                valid_q[upd_way_i][look_index_i] <= 1'b1;
                dirty_q[upd_way_i][look_index_i] <= 1'b0;
            end else if (set_dirty_i) begin
                dirty_q[upd_way_i][look_index_i] <= 1'b1;
            end
            if (touch_i) begin
                lru_q[look_index_i] <= ~upd_way_i;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (install_i) begin
            tag_q[upd_way_i][look_index_i] <= look_tag_i;
        end
    end

endmodule

`default_nettype wire

// ==== source/dcache_top.sv ====
/*
 * Two-way write-back data cache top level
 * Connects controller, tag store, data store and bus burst engine
 */
`timescale 1ns/10ps
`default_nettype none

module dcache_top (
    input  wire                    clk,
    input  wire                    srst_n,
    input  wire                    rd_req_i,
    input  wire dcache_pkg::byte_en_t wr_be_i,
    input  wire dcache_pkg::addr_t addr_i,
    input  wire dcache_pkg::word_t wdata_i,
    output logic                   req_accept_o,
    output logic                   busy_o,
    output logic                   rdata_valid_o,
    output logic                   wr_done_o,
    output dcache_pkg::word_t      rdata_o,
    output logic                   bus_req_o,
    output logic                   bus_we_o,
    input  wire                    bus_accept_i,
    output dcache_pkg::addr_t      bus_addr_o,
    output dcache_pkg::word_t      bus_wdata_o,
    input  wire dcache_pkg::word_t bus_rdata_i
);

    dcache_pkg::index_t   look_index;
    dcache_pkg::tag_t     look_tag;
    logic                 hit;
    dcache_pkg::way_t     hit_way;
    dcache_pkg::way_t     victim_way;
    logic                 victim_dirty;
    dcache_pkg::tag_t     victim_tag;
    logic                 touch;
    logic                 set_dirty;
    logic                 install;
    dcache_pkg::way_t     upd_way;
    logic                 mem_en;
    dcache_pkg::byte_en_t mem_be;
    dcache_pkg::way_t     mem_way;
    dcache_pkg::index_t   mem_index;
    dcache_pkg::offset_t  mem_offset;
    dcache_pkg::word_t    mem_wdata;
    dcache_pkg::word_t    mem_rdata;
    logic                 wb_start;
    logic                 fill_start;
    dcache_pkg::index_t   burst_index;
    dcache_pkg::tag_t     burst_tag;
    logic                 burst_done;
    dcache_pkg::offset_t  beat_offset;
    logic                 fill_we;
    dcache_pkg::word_t    fill_data;

    dcache_ctrl u_ctrl (
        .clk, .srst_n, .rd_req_i, .wr_be_i, .addr_i, .wdata_i,
        .req_accept_o, .busy_o, .rdata_valid_o, .wr_done_o, .rdata_o,
        .look_index_o(look_index), .look_tag_o(look_tag),
        .hit_i(hit), .hit_way_i(hit_way), .victim_way_i(victim_way),
        .victim_dirty_i(victim_dirty), .victim_tag_i(victim_tag),
        .touch_o(touch), .set_dirty_o(set_dirty), .install_o(install), .upd_way_o(upd_way),
        .mem_en_o(mem_en), .mem_be_o(mem_be), .mem_way_o(mem_way),
        .mem_index_o(mem_index), .mem_offset_o(mem_offset), .mem_wdata_o(mem_wdata),
        .mem_rdata_i(mem_rdata),
        .wb_start_o(wb_start), .fill_start_o(fill_start),
        .burst_index_o(burst_index), .burst_tag_o(burst_tag),
        .burst_done_i(burst_done), .beat_offset_i(beat_offset),
        .fill_we_i(fill_we), .fill_data_i(fill_data)
    );

    dcache_tag_store u_tag_store (
        .clk, .srst_n,
        .look_index_i(look_index), .look_tag_i(look_tag),
        .hit_o(hit), .hit_way_o(hit_way), .victim_way_o(victim_way),
        .victim_dirty_o(victim_dirty), .victim_tag_o(victim_tag),
        .touch_i(touch), .set_dirty_i(set_dirty), .install_i(install), .upd_way_i(upd_way)
    );

    dcache_data_store u_data_store (
        .clk,
        .en_i(mem_en), .be_i(mem_be), .way_i(mem_way), .index_i(mem_index),
        .offset_i(mem_offset), .wdata_i(mem_wdata), .rdata_o(mem_rdata)
    );

    dcache_bus_engine u_bus_engine (
        .clk, .srst_n,
        .wb_start_i(wb_start), .fill_start_i(fill_start),
        .burst_index_i(burst_index), .burst_tag_i(burst_tag), .mem_rdata_i(mem_rdata),
        .beat_offset_o(beat_offset), .fill_we_o(fill_we), .fill_data_o(fill_data),
        .burst_done_o(burst_done),
        .bus_req_o, .bus_we_o, .bus_accept_i, .bus_addr_o, .bus_wdata_o, .bus_rdata_i
    );

endmodule

`default_nettype wire

// ==== verification/dcache_props.sv ====
/*
 * Concurrent assertions on the core and bus handshakes,
 * bound to the cache top level
 */
`timescale 1ns/10ps
`default_nettype none

module dcache_props (
    input wire                    clk,
    input wire                    srst_n,
    input wire                    req_accept_o,
    input wire                    busy_o,
    input wire                    rdata_valid_o,
    input wire                    wr_done_o,
    input wire                    bus_req_o,
    input wire                    bus_accept_i,
    input wire dcache_pkg::addr_t bus_addr_o,
    input wire dcache_pkg::word_t bus_wdata_o
);

    // A stalled beat keeps its address and write data
    assert property (@(posedge clk) disable iff (!srst_n)
        bus_req_o && !bus_accept_i |=> $stable(bus_addr_o) && $stable(bus_wdata_o))
        else $error("bus beat changed while waiting for accept");

    assert property (@(posedge clk) disable iff (!srst_n) !(rdata_valid_o && wr_done_o))
        else $error("read and write results in the same cycle");

    // A hit answers in the next cycle, a miss holds off new requests instead
    assert property (@(posedge clk) disable iff (!srst_n)
        req_accept_o |=> busy_o || rdata_valid_o || wr_done_o)
        else $error("accepted request got neither a result nor a busy cycle");

    assert property (@(posedge clk) !srst_n |=> !bus_req_o)
        else $error("bus request active right after reset");

endmodule

bind dcache_top dcache_props dcache_props_inst (.*);

`default_nettype wire

// ==== verification/dcache_tb.sv ====
/*
 * Testbench for the two-way data cache: clock, reset, bus memory model,
 * directed and random requests, reference model, compare tasks and watchdog
 */
`timescale 1ns/10ps
`default_nettype none

module dcache_tb;

    localparam int unsigned SEED        = 32'haed5;
    localparam int          RAND_REQS   = 300;
    localparam int          NUM_REQS    = RAND_REQS + 24;
    localparam int          REQ_LIMIT   = 400;
    // 40 beats of 20 ns per request, plus margin
    localparam int          WATCHDOG_NS = NUM_REQS * 40 * 20 + 20000;

    logic                 clk;
    logic                 srst_n;
    logic                 rd_req_i;
    dcache_pkg::byte_en_t wr_be_i;
    dcache_pkg::addr_t    addr_i;
    dcache_pkg::word_t    wdata_i;
    logic                 req_accept_o;
    logic                 busy_o;
    logic                 rdata_valid_o;
    logic                 wr_done_o;
    dcache_pkg::word_t    rdata_o;
    logic                 bus_req_o;
    logic                 bus_we_o;
    logic                 bus_accept_i;
    dcache_pkg::addr_t    bus_addr_o;
    dcache_pkg::word_t    bus_wdata_o;
    dcache_pkg::word_t    bus_rdata_i;

    int                   errors;
    int                   fill_beats;
    int                   wb_beats;
    dcache_pkg::word_t    golden [bit [29:0]];
    dcache_pkg::word_t    bus_mem [bit [29:0]];
    dcache_pkg::word_t    exp_rdata [$];
    dcache_pkg::addr_t    req_addr;
    dcache_pkg::addr_t    wb_line;
    logic                 wb_check;
    logic [2:0]           fill_cnt;
    logic [2:0]           wb_cnt;

    dcache_top dcache_top_inst (.*);

    always #10 clk = ~clk;

    // Contents of words never written, mixed from the whole word address
    function automatic dcache_pkg::word_t addr_hash(input dcache_pkg::addr_t addr);
        dcache_pkg::addr_t a;
        a = {addr[31:2], 2'b00};
        return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]};
    endfunction

    function automatic dcache_pkg::addr_t make_addr(input logic [20:0] tag,
            input logic [5:0] index, input logic [2:0] offset);
        return {tag, index, offset, 2'b00};
    endfunction

    function automatic dcache_pkg::word_t merge_bytes(input dcache_pkg::word_t old_w,
            input dcache_pkg::word_t new_w, input dcache_pkg::byte_en_t be);
        dcache_pkg::word_t res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

    function automatic dcache_pkg::word_t expected_word(input dcache_pkg::addr_t addr);
        if (golden.exists(addr[31:2])) begin
            return golden[addr[31:2]];
        end
        return addr_hash(addr);
    endfunction

    function automatic dcache_pkg::word_t bus_read(input dcache_pkg::addr_t addr);
        if (bus_mem.exists(addr[31:2])) begin
            return bus_mem[addr[31:2]];
        end
        return addr_hash(addr);
    endfunction

    task automatic check_word(input string name, input dcache_pkg::word_t exp,
            input dcache_pkg::word_t act);
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s expected %h actual %h at %0t", name, exp, act, $time);
        end
    endtask

    task automatic check_addr(input string name, input dcache_pkg::addr_t exp,
            input dcache_pkg::addr_t act);
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s expected %h actual %h at %0t", name, exp, act, $time);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s expected %h actual %h at %0t", name, exp, act, $time);
        end
    endtask

    task automatic check_latency(input string what, input int lat);
        if (lat != 1) begin
            errors++;
            $display("%s result came %0d cycles after acceptance instead of 1", what, lat);
        end
    endtask

    // Called at a falling edge, returns cycles from acceptance to the result pulse
    task automatic do_request(input logic rd, input dcache_pkg::byte_en_t be,
            input dcache_pkg::addr_t addr, input dcache_pkg::word_t wdata, output int lat);
        int   waited;
        logic accepted;
        logic done;
        lat      = 0;
        waited   = 0;
        done     = 1'b0;
        req_addr = addr;
        rd_req_i = rd;
        wr_be_i  = be;
        addr_i   = addr;
        wdata_i  = wdata;
        do begin
            @(posedge clk);
            waited++;
        end while (!req_accept_o && waited < REQ_LIMIT);
        accepted = req_accept_o;
        if (!accepted) begin
            errors++;
            $display("Request to %h was never accepted", addr);
        end else if (rd) begin
            exp_rdata.push_back(expected_word(addr));
        end else begin
            golden[addr[31:2]] = merge_bytes(expected_word(addr), wdata, be);
        end
        do begin
            @(negedge clk);
            rd_req_i = 1'b0;
            wr_be_i  = '0;
            lat++;
            done = rd ? rdata_valid_o : wr_done_o;
        end while (accepted && !done && lat < REQ_LIMIT);
        if (accepted && !done) begin
            errors++;
            $display("No result pulse for the request to %h", addr);
        end
    endtask

    // Bus memory model, accept and read data change on the falling edge
    always @(negedge clk) begin
        bus_accept_i = (($urandom % 100) < 70);
        bus_rdata_i  = bus_read(bus_addr_o);
    end

    always @(posedge clk) begin
        if (srst_n && bus_req_o && bus_accept_i) begin
            if (bus_we_o) begin
                if (wb_check) begin
                    check_addr("bus_addr_o", {wb_line[31:5], wb_cnt, 2'b00}, bus_addr_o);
                end
                bus_mem[bus_addr_o[31:2]] = bus_wdata_o;
                wb_cnt = wb_cnt + 3'd1;
                wb_beats++;
            end else begin
                check_addr("bus_addr_o", {req_addr[31:5], fill_cnt, 2'b00}, bus_addr_o);
                fill_cnt = fill_cnt + 3'd1;
                fill_beats++;
            end
        end
    end

    always @(negedge clk) begin
        if (srst_n && rdata_valid_o) begin
            if (exp_rdata.size() == 0) begin
                errors++;
                $display("Read data returned with no read outstanding at %0t", $time);
            end else begin
                check_word("rdata_o", exp_rdata.pop_front(), rdata_o);
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns with %0d errors", WATCHDOG_NS, errors);
        $display("Regression failed");
        $finish;
    end

    initial begin
        int                lat;
        int                beats0;
        logic [20:0]       tag;
        logic [5:0]        idx;
        dcache_pkg::addr_t a;
        void'($urandom(SEED));
        errors       = 0;
        fill_beats   = 0;
        wb_beats     = 0;
        fill_cnt     = '0;
        wb_cnt       = '0;
        wb_check     = 1'b0;
        wb_line      = '0;
        req_addr     = '0;
        clk          = 1'b0;
        srst_n       = 1'b0;
        rd_req_i     = 1'b0;
        wr_be_i      = '0;
        addr_i       = '0;
        wdata_i      = '0;
        bus_accept_i = 1'b0;
        bus_rdata_i  = '0;
        repeat (4) @(negedge clk);
        srst_n = 1'b1;
        check_bit("busy_o", 1'b0, busy_o);
        check_bit("bus_req_o", 1'b0, bus_req_o);
        check_bit("rdata_valid_o", 1'b0, rdata_valid_o);
        check_bit("wr_done_o", 1'b0, wr_done_o);

        // Cold read, then partial write hit and read hit in the same line
        a = make_addr(21'h01234, 6'd3, 3'd2);
        beats0 = fill_beats;
        do_request(1'b1, 4'h0, a, '0, lat);
        if (fill_beats - beats0 != 8) begin
            errors++;
            $display("First read fetched %0d fill beats instead of 8", fill_beats - beats0);
        end
        do_request(1'b0, 4'b0110, make_addr(21'h01234, 6'd3, 3'd3), 32'hcafe_f00d, lat);
        check_latency("Write hit", lat);
        do_request(1'b1, 4'h0, make_addr(21'h01234, 6'd3, 3'd3), '0, lat);
        check_latency("Read hit", lat);

        // Write miss allocates the whole line
        do_request(1'b0, 4'b1001, make_addr(21'h00abc, 6'd17, 3'd5), 32'h1357_9bdf, lat);
        for (int i = 0; i < 8; i++) begin
            do_request(1'b1, 4'h0, make_addr(21'h00abc, 6'd17, i[2:0]), '0, lat);
        end

        // Three tags at one index, the third evicts the first dirty line
        do_request(1'b0, 4'hf, make_addr(21'h00111, 6'd40, 3'd1), 32'h1111_1111, lat);
        do_request(1'b0, 4'hf, make_addr(21'h00222, 6'd40, 3'd6), 32'h2222_2222, lat);
        wb_check = 1'b1;
        wb_line  = make_addr(21'h00111, 6'd40, 3'd0);
        beats0   = wb_beats;
        do_request(1'b0, 4'hf, make_addr(21'h00333, 6'd40, 3'd2), 32'h3333_3333, lat);
        if (wb_beats - beats0 != 8) begin
            errors++;
            $display("Eviction wrote back %0d beats instead of 8", wb_beats - beats0);
        end
        wb_line = make_addr(21'h00222, 6'd40, 3'd0);
        do_request(1'b1, 4'h0, make_addr(21'h00111, 6'd40, 3'd1), '0, lat);
        wb_check = 1'b0;

        // Random mix over two sets and three tags
        for (int n = 0; n < RAND_REQS; n++) begin
            tag = 21'h00040 + 21'($urandom % 3);
            idx = 6'd8 + 6'($urandom % 2);
            a   = make_addr(tag, idx, 3'($urandom));
            if ($urandom % 2) begin
                do_request(1'b1, 4'h0, a, '0, lat);
            end else begin
                do_request(1'b0, 4'(($urandom % 15) + 1), a, $urandom, lat);
            end
        end

        repeat (4) @(negedge clk);
        if (exp_rdata.size() != 0) begin
            errors++;
            $display("%0d reads finished without returning data", exp_rdata.size());
        end
        $display("Checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
